/* tb.f */
logic/lsu_pkg.sv
logic/soc_map_pkg.sv
logic/ex_mem_reg.sv
logic/mem_access.sv
logic/clint_timer.sv
logic/data_ram.sv
logic/mem_wb_reg.sv
logic/mem_subsys_top.sv
verif/mem_subsys_properties.sv
verif/tb_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_subsys)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

/* verif/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int RAM_LAT  = 2;
  localparam int WAIT_MAX = 20;  // cycles per request
  localparam logic [63:0] PAT = 64'h8A7B_6C5D_F4E3_92A1;

  logic              clk;
  logic              reset_i;
  logic              req_valid_i;
  lsu_pkg::mem_req_t req_i;
  logic              busy_o;
  logic              wb_valid_o;
  lsu_pkg::wb_t      wb_o;
  logic              timer_irq_o;

  logic [7:0]  ref_mem [128];  // first 16 doublewords of the ram
  logic [63:0] pc_cnt;
  integer      seed;
  int          errors;
  int          failed;
  int          tests;

  mem_subsys_top #(.RAM_WORDS(256), .RAM_LATENCY(RAM_LAT)) i_dut (
    .clk, .reset_i, .req_valid_i, .req_i, .busy_o, .wb_valid_o, .wb_o, .timer_irq_o
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic int op_bytes(input lsu_pkg::memop_e op);
    case (op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
      lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: return 4;
      default:                                return 8;
    endcase
  endfunction

  function automatic logic [63:0] ram_addr(input int byte_off);
    return 64'(soc_map_pkg::RAM_BASE) + 64'(byte_off);
  endfunction

  // little endian byte order with sign fill for LB, LH and LW
  function automatic logic [63:0] model_load(input int off, input lsu_pkg::memop_e op);
    logic [63:0] v;
    int          n;
    n = op_bytes(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = ref_mem[off + i];
    end
    if (op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW} && v[8*n-1]) begin
      for (int i = n; i < 8; i++) begin
        v[8*i +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  // issues one request and checks timing and payload of its writeback
  task automatic issue_req(input lsu_pkg::memop_e op, input logic [63:0] addr,
                           input logic [63:0] wdata, output logic [63:0] rdata);
    lsu_pkg::mem_req_t r;
    logic              is_ram;
    int                off;
    int                n;
    r.pc       = pc_cnt;
    r.inst     = $random(seed);
    r.rd_idx   = 5'($random(seed));
    r.rs2_data = wdata;
    r.mem_op   = op;
    r.alu_data = addr;
    pc_cnt     = pc_cnt + 64'd4;
    is_ram = (op != lsu_pkg::NONE) && (addr[31:0] != soc_map_pkg::MTIME_ADDR)
             && (addr[31:0] != soc_map_pkg::MTIMECMP_ADDR);
    off = int'(addr[31:0] - soc_map_pkg::RAM_BASE);
    rdata = '0;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= r;
    @(posedge clk);
    req_valid_i <= 1'b0;
    n = 1;
    @(negedge clk);
    while (!wb_valid_o && n < WAIT_MAX) begin
      compare_value("busy_o", 64'(is_ram && n <= RAM_LAT), 64'(busy_o));
      @(posedge clk);
      n++;
      @(negedge clk);
    end
    if (!wb_valid_o) begin
      $display("timeout, no writeback within %0d cycles of a request", WAIT_MAX);
      errors++;
    end else begin
      compare_value("wb latency", is_ram ? 64'(RAM_LAT + 2) : 64'd2, 64'(n));
      compare_value("wb_o.pc", r.pc, wb_o.pc);
      compare_value("wb_o.inst", 64'(r.inst), 64'(wb_o.inst));
      compare_value("wb_o.rd_idx", 64'(r.rd_idx), 64'(wb_o.rd_idx));
      rdata = wb_o.data;
      if (is_ram && op >= lsu_pkg::SB) begin
        for (int i = 0; i < op_bytes(op); i++) begin
          ref_mem[off + i] = wdata[8*i +: 8];
        end
      end else if (is_ram) begin
        compare_value("wb_o.data", model_load(off, op), wb_o.data);
      end else if (op == lsu_pkg::NONE) begin
        compare_value("wb_o.data", addr, wb_o.data);
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    compare_value("wb_valid_o", 64'd0, 64'(wb_valid_o));
    compare_value("busy_o", 64'd0, 64'(busy_o));
    compare_value("timer_irq_o", 64'd0, 64'(timer_irq_o));
    report_test("reset state", e0);
  endtask

  task automatic store_load_widths();
    lsu_pkg::memop_e st_ops [4];
    lsu_pkg::memop_e sl_ops [4];
    lsu_pkg::memop_e ul_ops [3];
    logic [63:0]     d;
    logic [63:0]     rd;
    int              nb;
    int              e0;
    e0     = errors;
    st_ops = '{lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD};
    sl_ops = '{lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD};
    ul_ops = '{lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU};
    // each doubleword starts out tagged with its own address
    for (int w = 0; w < 16; w++) begin
      d = ram_addr(8 * w);
      issue_req(lsu_pkg::SD, d, {~d[31:0], d[31:0]}, rd);
    end
    for (int sz = 0; sz < 4; sz++) begin
      nb = 1 << sz;
      for (int k = 0; k < 8; k += nb) begin
        d = (((k / nb) % 2 == 1) ? ~PAT : PAT) >> (8 * k);
        issue_req(st_ops[sz], ram_addr(8 * (2 + sz) + k), d, rd);
        issue_req(sl_ops[sz], ram_addr(8 * (2 + sz) + k), 64'd0, rd);
        if (sz < 3) begin
          issue_req(ul_ops[sz], ram_addr(8 * (2 + sz) + k), 64'd0, rd);
        end
      end
    end
    // other bytes of the doubleword survive a lone byte store
    issue_req(lsu_pkg::SB, ram_addr(51), 64'h0000_0000_0000_00c3, rd);
    issue_req(lsu_pkg::LD, ram_addr(48), 64'd0, rd);
    report_test("store/load widths", e0);
  endtask

  task automatic latency_and_passthrough();
    logic [63:0] rd;
    int          e0;
    e0 = errors;
    issue_req(lsu_pkg::NONE, {$random(seed), $random(seed)}, 64'd0, rd);
    issue_req(lsu_pkg::LD, ram_addr(40), 64'd0, rd);  // busy until ready
    report_test("latency and passthrough", e0);
  endtask

  task automatic timer_access();
    logic [63:0] rd;
    logic [63:0] scratch;
    int          n;
    int          e0;
    e0 = errors;
    issue_req(lsu_pkg::SD, 64'(soc_map_pkg::MTIMECMP_ADDR), 64'h0004_0000, scratch);
    issue_req(lsu_pkg::LD, 64'(soc_map_pkg::MTIMECMP_ADDR), 64'd0, rd);
    compare_value("mtimecmp", 64'h0004_0000, rd);
    issue_req(lsu_pkg::SD, 64'(soc_map_pkg::MTIME_ADDR), 64'h1000, scratch);
    issue_req(lsu_pkg::LD, 64'(soc_map_pkg::MTIME_ADDR), 64'd0, rd);
    assert (rd >= 64'h1000 && rd <= 64'h1004) else begin
      $display("ERROR %0t mtime expected 1000 to 1004 actual %h", $time, rd);
      errors++;
    end
    compare_value("timer_irq_o", 64'd0, 64'(timer_irq_o));
    // compare value a few ticks ahead
    issue_req(lsu_pkg::SD, 64'(soc_map_pkg::MTIMECMP_ADDR), rd + 64'd12, scratch);
    n = 0;
    while (!timer_irq_o && n < 50) begin
      @(negedge clk);
      n++;
    end
    assert (timer_irq_o) else begin
      $display("%0t timer_irq_o did not rise within 50 cycles", $time);
      errors++;
    end
    report_test("timer", e0);
  endtask

  task automatic random_traffic();
    lsu_pkg::memop_e op;
    logic [63:0]     d;
    logic [63:0]     rd;
    int              w;
    int              k;
    int              e0;
    e0 = errors;
    for (int i = 0; i < 40; i++) begin
      op = lsu_pkg::memop_e'(4'(1 + $unsigned($random(seed)) % 11));
      w  = int'($unsigned($random(seed)) % 16);
      k  = int'($unsigned($random(seed)) % 8) & ~(op_bytes(op) - 1);  // natural alignment
      d  = {$random(seed), $random(seed)};
      issue_req(op, ram_addr(8 * w + k), d, rd);
    end
    report_test("random traffic", e0);
  endtask

  initial begin
    seed        = 73;
    errors      = 0;
    failed      = 0;
    tests       = 0;
    pc_cnt      = 64'h0000_0000_8000_1000;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    reset_state();
    store_load_widths();
    latency_and_passthrough();
    timer_access();
    random_traffic();
    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verif/mem_subsys_properties.sv */
`timescale 1ns/1ps

module mem_subsys_properties (
  input logic clk,
  input logic reset_i,
  input logic req_valid_i,
  input logic busy_i,
  input logic wb_valid_i
);

  // source holds off while a ram access is pending
  no_strobe_when_busy: assert property (
    @(posedge clk) disable iff (reset_i) req_valid_i |-> !busy_i
  ) else $error("request strobe while busy_o is high");

  single_wb_strobe: assert property (
    @(posedge clk) disable iff (reset_i) wb_valid_i |=> !wb_valid_i
  ) else $error("wb_valid_o high on two consecutive cycles");

  idle_after_reset: assert property (
    @(posedge clk) reset_i |=> (!busy_i && !wb_valid_i)
  ) else $error("busy_o or wb_valid_o active right after reset");

endmodule

bind mem_subsys_top mem_subsys_properties i_props (
  .clk         (clk),
  .reset_i     (reset_i),
  .req_valid_i (req_valid_i),
  .busy_i      (busy_o),
  .wb_valid_i  (wb_valid_o)
);

/* logic/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int unsigned RAM_WORDS   = 256,
  parameter int unsigned RAM_LATENCY = 2
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               req_valid_i,
  input  lsu_pkg::mem_req_t  req_i,
  output logic               busy_o,
  output logic               wb_valid_o,
  output lsu_pkg::wb_t       wb_o,
  output logic               timer_irq_o
);

  logic                       occ;
  lsu_pkg::mem_req_t          req_q;
  logic                       retire;
  lsu_pkg::wb_t               wb_next;
  logic [lsu_pkg::ADDR_W-1:0] ram_addr;
  logic                       ram_req;
  logic                       ram_we;
  logic [7:0]                 ram_mask;
  logic [lsu_pkg::XLEN-1:0]   ram_wdata;
  logic                       ram_ready;
  logic [lsu_pkg::XLEN-1:0]   ram_rdata;
  logic                       tmr_sel;
  logic                       tmr_we;
  logic [lsu_pkg::ADDR_W-1:0] tmr_addr;
  logic [lsu_pkg::XLEN-1:0]   tmr_wdata;
  logic [lsu_pkg::XLEN-1:0]   tmr_rdata;

  ex_mem_reg i_ex_mem_reg (
    .clk, .reset_i, .req_valid_i, .req_i,
    .retire_i (retire), .occ_o (occ), .req_o (req_q)
  );

  mem_access i_mem_access (
    .occ_i (occ), .req_i (req_q),
    .ram_addr_o (ram_addr), .ram_req_o (ram_req), .ram_we_o (ram_we),
    .ram_mask_o (ram_mask), .ram_wdata_o (ram_wdata),
    .ram_ready_i (ram_ready), .ram_rdata_i (ram_rdata),
    .tmr_sel_o (tmr_sel), .tmr_we_o (tmr_we), .tmr_addr_o (tmr_addr),
    .tmr_wdata_o (tmr_wdata), .tmr_rdata_i (tmr_rdata),
    .retire_o (retire), .wb_o (wb_next), .busy_o
  );

  clint_timer i_clint_timer (
    .clk, .reset_i,
    .tmr_sel_i (tmr_sel), .tmr_we_i (tmr_we), .tmr_addr_i (tmr_addr),
    .tmr_wdata_i (tmr_wdata), .tmr_rdata_o (tmr_rdata), .timer_irq_o
  );

  data_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) i_data_ram (
    .clk, .reset_i,
    .ram_addr_i (ram_addr), .ram_req_i (ram_req), .ram_we_i (ram_we),
    .ram_mask_i (ram_mask), .ram_wdata_i (ram_wdata),
    .ram_ready_o (ram_ready), .ram_rdata_o (ram_rdata)
  );

  mem_wb_reg i_mem_wb_reg (
    .clk, .reset_i,
    .retire_i (retire), .wb_i (wb_next), .wb_valid_o, .wb_o
  );

endmodule

/* logic/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg (
  input  logic          clk,
  input  logic          reset_i,
  input  logic          retire_i,
  input  lsu_pkg::wb_t  wb_i,
  output logic          wb_valid_o,
  output lsu_pkg::wb_t  wb_o
);

  logic         valid_q;
  lsu_pkg::wb_t wb_q;

  // strobe is retire one cycle late
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= retire_i;
    end
  end

  // payload holds between strobes
  always_ff @(posedge clk) begin
    if (retire_i) begin
      wb_q <= wb_i;
    end
  end

  assign wb_valid_o = valid_q;
  assign wb_o       = wb_q;

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
  parameter int unsigned RAM_WORDS   = 256,
  parameter int unsigned RAM_LATENCY = 2
) (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  ram_addr_i,
  input  logic                        ram_req_i,
  input  logic                        ram_we_i,
  input  logic [7:0]                  ram_mask_i,
  input  logic [lsu_pkg::XLEN-1:0]    ram_wdata_i,
  output logic                        ram_ready_o,
  output logic [lsu_pkg::XLEN-1:0]    ram_rdata_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  logic [lsu_pkg::XLEN-1:0]   mem [RAM_WORDS];
  logic [lsu_pkg::ADDR_W-1:0] rel_addr;
  logic [IDX_W-1:0]           idx;
  logic [CNT_W-1:0]           cnt_q;
  logic                       ready_q;
  logic                       last_cycle;
  logic [lsu_pkg::XLEN-1:0]   rdata_q;

  assign rel_addr   = ram_addr_i - soc_map_pkg::RAM_BASE;
  assign idx        = rel_addr[IDX_W+2:3];  // doubleword index
  assign last_cycle = ram_req_i && (cnt_q == CNT_W'(RAM_LATENCY - 1));

  // count request cycles, ready goes out RAM_LATENCY cycles after req rises
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cnt_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= last_cycle && !ready_q;
      if (ready_q) begin
        cnt_q <= '0;
      end else if (ram_req_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (last_cycle) begin
      rdata_q <= mem[idx];
    end
    if (ready_q && ram_we_i) begin  // store lands at end of ready cycle
      for (int b = 0; b < 8; b++) begin
        if (ram_mask_i[b]) begin
          mem[idx][8*b +: 8] <= ram_wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign ram_ready_o = ready_q;
  assign ram_rdata_o = rdata_q;

endmodule

/* logic/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        tmr_sel_i,
  input  logic                        tmr_we_i,
  input  logic [lsu_pkg::ADDR_W-1:0]  tmr_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]    tmr_wdata_i,
  output logic [lsu_pkg::XLEN-1:0]    tmr_rdata_o,
  output logic                        timer_irq_o
);

  logic [lsu_pkg::XLEN-1:0] mtime_q;
  logic [lsu_pkg::XLEN-1:0] mtimecmp_q;
  logic                     irq_q;
  logic                     wr_mtime;
  logic                     wr_mtimecmp;

  assign wr_mtime    = tmr_sel_i && tmr_we_i && (tmr_addr_i == soc_map_pkg::MTIME_ADDR);
  assign wr_mtimecmp = tmr_sel_i && tmr_we_i && (tmr_addr_i == soc_map_pkg::MTIMECMP_ADDR);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else if (wr_mtime) begin
      mtime_q <= tmr_wdata_i;
    end else begin
      mtime_q <= mtime_q + 1'b1;  // free running
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      mtimecmp_q <= '1;  // no interrupt out of reset
    end else if (wr_mtimecmp) begin
      mtimecmp_q <= tmr_wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign tmr_rdata_o = (tmr_addr_i == soc_map_pkg::MTIMECMP_ADDR) ? mtimecmp_q : mtime_q;
  assign timer_irq_o = irq_q;

endmodule

/* logic/mem_access.sv */
`timescale 1ns/1ps

module mem_access (
  input  logic                          occ_i,
  input  lsu_pkg::mem_req_t             req_i,
  // data ram
  output logic [lsu_pkg::ADDR_W-1:0]    ram_addr_o,
  output logic                          ram_req_o,
  output logic                          ram_we_o,
  output logic [7:0]                    ram_mask_o,
  output logic [lsu_pkg::XLEN-1:0]      ram_wdata_o,
  input  logic                          ram_ready_i,
  input  logic [lsu_pkg::XLEN-1:0]      ram_rdata_i,
  // timer
  output logic                          tmr_sel_o,
  output logic                          tmr_we_o,
  output logic [lsu_pkg::ADDR_W-1:0]    tmr_addr_o,
  output logic [lsu_pkg::XLEN-1:0]      tmr_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0]      tmr_rdata_i,
  // writeback side
  output logic                          retire_o,
  output lsu_pkg::wb_t                  wb_o,
  output logic                          busy_o
);

  logic                       is_load;
  logic                       is_store;
  logic                       is_signed;
  logic [1:0]                 size_log2;  // 0:byte 1:half 2:word 3:double
  logic [7:0]                 base_mask;
  logic [lsu_pkg::XLEN-1:0]   store_trunc;
  logic [lsu_pkg::ADDR_W-1:0] addr;
  logic [2:0]                 off;
  logic                       tmr_hit;
  logic                       is_ram;
  logic [lsu_pkg::XLEN-1:0]   raw_rdata;
  logic [lsu_pkg::XLEN-1:0]   sh_rdata;
  logic [lsu_pkg::XLEN-1:0]   load_ext;

  always_comb begin
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_signed = 1'b0;
    size_log2 = 2'd0;
    case (req_i.mem_op)
      lsu_pkg::LB:  begin is_load = 1'b1; is_signed = 1'b1; size_log2 = 2'd0; end
      lsu_pkg::LBU: begin is_load = 1'b1; size_log2 = 2'd0; end
      lsu_pkg::LH:  begin is_load = 1'b1; is_signed = 1'b1; size_log2 = 2'd1; end
      lsu_pkg::LHU: begin is_load = 1'b1; size_log2 = 2'd1; end
      lsu_pkg::LW:  begin is_load = 1'b1; is_signed = 1'b1; size_log2 = 2'd2; end
      lsu_pkg::LWU: begin is_load = 1'b1; size_log2 = 2'd2; end
      lsu_pkg::LD:  begin is_load = 1'b1; is_signed = 1'b1; size_log2 = 2'd3; end
      lsu_pkg::SB:  begin is_store = 1'b1; size_log2 = 2'd0; end
      lsu_pkg::SH:  begin is_store = 1'b1; size_log2 = 2'd1; end
      lsu_pkg::SW:  begin is_store = 1'b1; size_log2 = 2'd2; end
      lsu_pkg::SD:  begin is_store = 1'b1; size_log2 = 2'd3; end
      default:      ;  // NONE, plain alu result
    endcase
  end

  // width-truncated store data and unshifted byte enables
  always_comb begin
    case (size_log2)
      2'd0:    begin base_mask = 8'h01; store_trunc = {56'b0, req_i.rs2_data[7:0]};  end
      2'd1:    begin base_mask = 8'h03; store_trunc = {48'b0, req_i.rs2_data[15:0]}; end
      2'd2:    begin base_mask = 8'h0f; store_trunc = {32'b0, req_i.rs2_data[31:0]}; end
      default: begin base_mask = 8'hff; store_trunc = req_i.rs2_data;                end
    endcase
  end

  assign addr    = req_i.alu_data[lsu_pkg::ADDR_W-1:0];
  assign off     = addr[2:0];
  assign tmr_hit = (addr == soc_map_pkg::MTIME_ADDR) || (addr == soc_map_pkg::MTIMECMP_ADDR);
  assign is_ram  = (is_load || is_store) && !tmr_hit;

  // ram request stays up until the ready cycle
  assign ram_addr_o  = addr;
  assign ram_req_o   = occ_i && is_ram && !ram_ready_i;
  assign ram_we_o    = occ_i && is_ram && is_store;
  assign ram_mask_o  = base_mask << off;
  assign ram_wdata_o = store_trunc << {off, 3'b000};

  assign tmr_sel_o   = occ_i && (is_load || is_store) && tmr_hit;
  assign tmr_we_o    = tmr_sel_o && is_store;
  assign tmr_addr_o  = addr;
  assign tmr_wdata_o = ram_wdata_o;  // full doubleword in practice

  // load path: pick source, shift down, extend
  assign raw_rdata = tmr_hit ? tmr_rdata_i : ram_rdata_i;
  assign sh_rdata  = raw_rdata >> {off, 3'b000};

  always_comb begin
    case (size_log2)
      2'd0:    load_ext = {{56{is_signed & sh_rdata[7]}}, sh_rdata[7:0]};
      2'd1:    load_ext = {{48{is_signed & sh_rdata[15]}}, sh_rdata[15:0]};
      2'd2:    load_ext = {{32{is_signed & sh_rdata[31]}}, sh_rdata[31:0]};
      default: load_ext = sh_rdata;
    endcase
  end

  assign retire_o    = occ_i && (is_ram ? ram_ready_i : 1'b1);
  assign busy_o      = ram_req_o;

  assign wb_o.pc     = req_i.pc;
  assign wb_o.inst   = req_i.inst;
  assign wb_o.rd_idx = req_i.rd_idx;
  assign wb_o.data   = is_load ? load_ext : req_i.alu_data;

endmodule

/* logic/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               req_valid_i,
  input  lsu_pkg::mem_req_t  req_i,
  input  logic               retire_i,
  output logic               occ_o,
  output lsu_pkg::mem_req_t  req_o
);

  logic              occ_q;
  lsu_pkg::mem_req_t req_q;

  // occupancy, a new strobe wins over retire on the same edge
  always_ff @(posedge clk) begin
    if (reset_i) begin
      occ_q <= 1'b0;
    end else if (req_valid_i) begin
      occ_q <= 1'b1;
    end else if (retire_i) begin
      occ_q <= 1'b0;
    end
  end

  // held stable for the whole ram access
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      req_q <= req_i;
    end
  end

  assign occ_o = occ_q;
  assign req_o = req_q;

endmodule

/* logic/soc_map_pkg.sv */
package soc_map_pkg;

  // core-local timer registers
  localparam logic [31:0] MTIME_ADDR    = 32'h0200_BFF8;
  localparam logic [31:0] MTIMECMP_ADDR = 32'h0200_4000;

  // data ram window starts here, size set by RAM_WORDS
  localparam logic [31:0] RAM_BASE = 32'h8000_0000;

endpackage

/* logic/lsu_pkg.sv */
package lsu_pkg;

  localparam int XLEN      = 64;
  localparam int ADDR_W    = 32;  // physical address
  localparam int INST_W    = 32;
  localparam int REG_IDX_W = 5;

  // memory opcodes from the execute stage
  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LBU  = 4'd2,
    LH   = 4'd3,
    LHU  = 4'd4,
    LW   = 4'd5,
    LWU  = 4'd6,
    LD   = 4'd7,
    SB   = 4'd8,
    SH   = 4'd9,
    SW   = 4'd10,
    SD   = 4'd11
  } memop_e;

  // request handed over by execute
  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [INST_W-1:0]    inst;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      rs2_data;  // store data
    memop_e               mem_op;
    logic [XLEN-1:0]      alu_data;  // also the address
  } mem_req_t;

  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [INST_W-1:0]    inst;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      data;
  } wb_t;

endpackage
